/* verilog/line_window_pkg.sv */
package line_window_pkg;

    ////////////////////////////////////////
    // widths and defaults
    ////////////////////////////////////////

    parameter int PIX_W = 8;

    parameter int DEF_ROW_W = 256;
    parameter int DEF_COL_H = 256;
    parameter int DEF_ROWS  = 3;

    typedef logic [PIX_W-1:0] pix_t;

    ////////////////////////////////////////
    // stream types
    ////////////////////////////////////////

    // raw raster input, sampled every clock
    typedef struct packed {
        logic line;
        logic frame;
        pix_t pix;
    } pix_in_t;

    // registered stream plus edge events
    typedef struct packed {
        pix_t pix;
        logic frame;
        logic active;
        logic line_start;
        logic line_end;
        logic frame_end;
        logic last_row;
        logic row_done;
    } stream_evt_t;

    // place of a row inside its group
    typedef enum logic [1:0] {
        SLOT_FIRST,
        SLOT_MID,
        SLOT_LAST
    } slot_e;

endpackage

/* verilog/sync_tracker.sv */
`timescale 1ns/1ps

module sync_tracker import line_window_pkg::*; #(
    parameter int COL_H = DEF_COL_H
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  pix_in_t     i_stream,
    output stream_evt_t o_evt
);

    pix_in_t     r_stream;
    logic        r_active_d;
    logic        r_frame_d;
    logic [15:0] r_row_cnt;
    logic        active;

    assign active = r_stream.line & r_stream.frame;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_stream   <= '0;
            r_active_d <= 1'b0;
            r_frame_d  <= 1'b0;
        end else begin
            r_stream   <= i_stream;
            r_active_d <= active;
            r_frame_d  <= r_stream.frame;
        end
    end

    // completed rows in the current frame
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_row_cnt <= 16'd0;
        end else if (!r_stream.frame) begin
            r_row_cnt <= 16'd0;
        end else if (!active && r_active_d) begin
            r_row_cnt <= r_row_cnt + 16'd1;
        end
    end

    always_comb begin
        o_evt            = '0;
        o_evt.pix        = r_stream.pix;
        o_evt.frame      = r_stream.frame;
        o_evt.active     = active;
        o_evt.line_start = active & ~r_active_d;
        o_evt.line_end   = ~active & r_active_d;
        o_evt.frame_end  = ~r_stream.frame & r_frame_d;
        // high across the whole of row H-1
        o_evt.last_row   = active && (r_row_cnt == 16'(COL_H - 1));
        o_evt.row_done   = (r_row_cnt == 16'(COL_H));
    end

endmodule

/* verilog/line_write_ctrl.sv */
`timescale 1ns/1ps

module line_write_ctrl import line_window_pkg::*; #(
    parameter int ROW_W = DEF_ROW_W,
    parameter int ROWS  = DEF_ROWS
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  stream_evt_t              i_evt,
    output slot_e                    o_slot,
    output logic [$clog2(ROWS)-1:0]  o_slot_idx,
    output logic [ROWS-2:0]          o_we,
    output logic [$clog2(ROW_W)-1:0] o_waddr,
    output pix_t                     o_wdata
);

    localparam int IDX_W  = $clog2(ROWS);
    localparam int ADDR_W = $clog2(ROW_W);

    logic [IDX_W-1:0] r_idx;

    // row slot, wraps after N-1 and restarts every frame
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_idx <= '0;
        end else if (i_evt.frame_end) begin
            r_idx <= '0;
        end else if (i_evt.line_end) begin
            r_idx <= (r_idx == IDX_W'(ROWS - 1)) ? '0 : r_idx + 1'b1;
        end
    end

    assign o_slot_idx = r_idx;
    assign o_slot     = (r_idx == '0)                 ? SLOT_FIRST :
                        (r_idx == IDX_W'(ROWS - 1))   ? SLOT_LAST  : SLOT_MID;

    ////////////////////////////////////////
    // write steering
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_we    <= '0;
            o_waddr <= '0;
        end else begin
            for (int k = 0; k < ROWS - 1; k++) begin
                o_we[k] <= i_evt.active && (r_idx == IDX_W'(k));
            end
            // address follows the enable, back to 0 between rows
            o_waddr <= (|o_we) ? o_waddr + 1'b1 : ADDR_W'(0);
        end
    end

    always_ff @(posedge i_clk) begin
        o_wdata <= i_evt.pix;
    end

endmodule

/* verilog/line_ram.sv */
`timescale 1ns/1ps

module line_ram import line_window_pkg::*; #(
    parameter int ROW_W = DEF_ROW_W
) (
    input  logic                     i_clk,
    input  logic                     i_we,
    input  logic [$clog2(ROW_W)-1:0] i_waddr,
    input  pix_t                     i_wdata,
    input  logic                     i_re,
    input  logic [$clog2(ROW_W)-1:0] i_raddr,
    output pix_t                     o_rdata
);

    pix_t mem [ROW_W];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // one cycle read latency
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

/* verilog/row_assembler.sv */
`timescale 1ns/1ps

module row_assembler import line_window_pkg::*; #(
    parameter int ROW_W = DEF_ROW_W,
    parameter int COL_H = DEF_COL_H,
    parameter int ROWS  = DEF_ROWS
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  stream_evt_t              i_evt,
    input  slot_e                    i_slot,
    input  logic [$clog2(ROWS)-1:0]  i_slot_idx,
    output logic                     o_re,
    output logic [$clog2(ROW_W)-1:0] o_raddr,
    input  pix_t [ROWS-2:0]          i_rdata,
    output logic [PIX_W*ROWS-1:0]    o_win,
    output logic                     o_win_valid,
    output logic                     o_partial,
    output logic                     o_frame
);

    localparam int   IDX_W  = $clog2(ROWS);
    localparam int   ADDR_W = $clog2(ROW_W);
    localparam int   REM    = COL_H % ROWS;
    localparam pix_t PAD    = pix_t'(REM);

    logic             r_re_d1;
    logic             r_part;
    logic [IDX_W-1:0] r_part_idx;
    logic             r_frame_d1;
    pix_t             r_pix_d1;
    pix_t             r_pix_d2;
    pix_t [ROWS-1:0]  mem_ext;
    logic [IDX_W-1:0] live_idx;
    logic [PIX_W*ROWS-1:0] win_nxt;

    ////////////////////////////////////////
    // read burst
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_re       <= 1'b0;
            r_part     <= 1'b0;
            r_part_idx <= '0;
        end else if (i_evt.line_end) begin
            o_re <= 1'b0;
        end else if (i_evt.line_start && !i_evt.row_done &&
                     (i_slot == SLOT_LAST || i_evt.last_row)) begin
            o_re       <= 1'b1;
            // closing on the last row short of a full group
            r_part     <= i_evt.last_row && (REM != 0);
            r_part_idx <= i_slot_idx;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_raddr <= '0;
        end else begin
            o_raddr <= o_re ? o_raddr + 1'b1 : ADDR_W'(0);
        end
    end

    // live pixel lines up with ram data
    always_ff @(posedge i_clk) begin
        r_pix_d1 <= i_evt.pix;
        r_pix_d2 <= r_pix_d1;
    end

    ////////////////////////////////////////
    // packing
    ////////////////////////////////////////

    assign mem_ext  = {PAD, i_rdata};
    assign live_idx = r_part ? r_part_idx : IDX_W'(ROWS - 1);

    // oldest row in the top field
    always_comb begin
        win_nxt = '0;
        for (int f = 0; f < ROWS; f++) begin
            if (IDX_W'(f) < live_idx) begin
                win_nxt[(ROWS-f)*PIX_W-1 -: PIX_W] = mem_ext[f];
            end else if (IDX_W'(f) == live_idx) begin
                win_nxt[(ROWS-f)*PIX_W-1 -: PIX_W] = r_pix_d2;
            end else begin
                win_nxt[(ROWS-f)*PIX_W-1 -: PIX_W] = PAD;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_re_d1     <= 1'b0;
            o_win_valid <= 1'b0;
            o_partial   <= 1'b0;
            o_win       <= '0;
        end else begin
            r_re_d1     <= o_re;
            o_win_valid <= r_re_d1;
            o_partial   <= r_re_d1 && r_part;
            o_win       <= r_re_d1 ? win_nxt : '0;
        end
    end

    // frame flag, 3 cycles behind the input
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_frame_d1 <= 1'b0;
            o_frame    <= 1'b0;
        end else begin
            r_frame_d1 <= i_evt.frame;
            o_frame    <= r_frame_d1;
        end
    end

endmodule

/* verilog/line_window_top.sv */
`timescale 1ns/1ps

module line_window_top import line_window_pkg::*; #(
    parameter int ROW_W = DEF_ROW_W,
    parameter int COL_H = DEF_COL_H,
    parameter int ROWS  = DEF_ROWS
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  pix_in_t               i_stream,
    output logic [PIX_W*ROWS-1:0] o_win,
    output logic                  o_win_valid,
    output logic                  o_partial,
    output logic                  o_frame
);

    localparam int IDX_W  = $clog2(ROWS);
    localparam int ADDR_W = $clog2(ROW_W);

    stream_evt_t       evt;
    slot_e             slot;
    logic [IDX_W-1:0]  slot_idx;
    logic [ROWS-2:0]   we;
    logic [ADDR_W-1:0] waddr;
    pix_t              wdata;
    logic              re;
    logic [ADDR_W-1:0] raddr;
    pix_t [ROWS-2:0]   rdata;

    sync_tracker #(
        .COL_H (COL_H)
    ) u_sync_tracker (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_stream (i_stream),
        .o_evt    (evt)
    );

    line_write_ctrl #(
        .ROW_W (ROW_W),
        .ROWS  (ROWS)
    ) u_line_write_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_evt      (evt),
        .o_slot     (slot),
        .o_slot_idx (slot_idx),
        .o_we       (we),
        .o_waddr    (waddr),
        .o_wdata    (wdata)
    );

    // one memory per stored row of a group
    for (genvar k = 0; k < ROWS - 1; k++) begin : g_line_ram
        line_ram #(
            .ROW_W (ROW_W)
        ) u_line_ram (
            .i_clk   (i_clk),
            .i_we    (we[k]),
            .i_waddr (waddr),
            .i_wdata (wdata),
            .i_re    (re),
            .i_raddr (raddr),
            .o_rdata (rdata[k])
        );
    end

    row_assembler #(
        .ROW_W (ROW_W),
        .COL_H (COL_H),
        .ROWS  (ROWS)
    ) u_row_assembler (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_evt       (evt),
        .i_slot      (slot),
        .i_slot_idx  (slot_idx),
        .o_re        (re),
        .o_raddr     (raddr),
        .i_rdata     (rdata),
        .o_win       (o_win),
        .o_win_valid (o_win_valid),
        .o_partial   (o_partial),
        .o_frame     (o_frame)
    );

endmodule

/* bench/tb_line_window.sv */
`timescale 1ns/1ps

module tb_line_window import line_window_pkg::*; ();

    localparam int   ROW_W = 16;
    localparam int   COL_H = 8;
    localparam int   ROWS  = 3;
    localparam int   WIN_W = PIX_W * ROWS;
    localparam int   FRAME_WORDS = ((COL_H + ROWS - 1) / ROWS) * ROW_W;
    localparam pix_t PAD = pix_t'(COL_H % ROWS);

    logic             i_clk;
    logic             i_rst_n;
    pix_in_t          i_stream;
    logic [WIN_W-1:0] o_win;
    logic             o_win_valid;
    logic             o_partial;
    logic             o_frame;

    // expected outputs, driven in step with i_stream
    logic             ref_valid;
    logic             ref_partial;
    logic [WIN_W-1:0] ref_word;
    logic [3:0]       valid_pipe;
    logic [3:0]       part_pipe;
    logic [WIN_W-1:0] word_pipe [4];
    logic [2:0]       frm_pipe;

    pix_t img [COL_H][ROW_W];
    int   seed;
    int   cyc;
    int   word_cnt;
    int   run_len;
    int   err_value;
    int   err_other;
    logic quiet;

    line_window_top #(
        .ROW_W (ROW_W),
        .COL_H (COL_H),
        .ROWS  (ROWS)
    ) i_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stream    (i_stream),
        .o_win       (o_win),
        .o_win_valid (o_win_valid),
        .o_partial   (o_partial),
        .o_frame     (o_frame)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
        err_value++;
        $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_other(string what);
        err_other++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic drive(logic line, logic frame, pix_t pix, logic valid, logic part,
                         logic [WIN_W-1:0] word);
        @(posedge i_clk);
        i_stream    <= '{line: line, frame: frame, pix: pix};
        ref_valid   <= valid;
        ref_partial <= part;
        ref_word    <= word;
    endtask

    // rows of the group up to r, oldest on top, missing rows padded
    function automatic logic [WIN_W-1:0] expected_word(int r, int x);
        logic [WIN_W-1:0] w;
        int first;
        first = (r / ROWS) * ROWS;
        w = '0;
        for (int f = 0; f < ROWS; f++) begin
            w[WIN_W-1-f*PIX_W -: PIX_W] = (first + f <= r) ? img[first+f][x] : PAD;
        end
        return w;
    endfunction

    task automatic send_frame();
        logic closing;
        logic part;
        for (int r = 0; r < COL_H; r++) begin
            for (int x = 0; x < ROW_W; x++) begin
                img[r][x] = pix_t'($random(seed));
            end
        end
        repeat (2) drive(1'b0, 1'b1, '0, 1'b0, 1'b0, '0);
        for (int r = 0; r < COL_H; r++) begin
            closing = (r % ROWS == ROWS - 1) || (r == COL_H - 1);
            part    = closing && (r == COL_H - 1) && (COL_H % ROWS != 0);
            for (int x = 0; x < ROW_W; x++) begin
                drive(1'b1, 1'b1, img[r][x], closing, part,
                      closing ? expected_word(r, x) : '0);
            end
            if (r < COL_H - 1) begin
                repeat (3) drive(1'b0, 1'b1, '0, 1'b0, 1'b0, '0);
            end
        end
        repeat (6) drive(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic wait_words(int target);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < 100) begin
            @(posedge i_clk);
            n++;
            done = (word_cnt >= target) && !o_win_valid;
        end
        if (!done) begin
            report_other("output words of the frame never finished");
        end else if (word_cnt != target) begin
            report_value("word count", word_cnt, target);
        end
    endtask

    ////////////////////////////////////////
    // delay lines and scoreboard
    ////////////////////////////////////////

    assign quiet = (cyc < 18);

    always @(posedge i_clk) begin
        cyc          <= cyc + 1;
        frm_pipe     <= {frm_pipe[1:0], i_stream.frame};
        valid_pipe   <= {valid_pipe[2:0], ref_valid};
        part_pipe    <= {part_pipe[2:0], ref_partial};
        word_pipe[0] <= ref_word;
        for (int k = 1; k < 4; k++) begin
            word_pipe[k] <= word_pipe[k-1];
        end
    end

    always @(posedge i_clk) begin
        if (o_win_valid) begin
            word_cnt <= word_cnt + 1;
            run_len  <= run_len + 1;
        end else if (run_len != 0) begin
            if (run_len != ROW_W) begin
                report_value("valid run length", run_len, ROW_W);
            end
            run_len <= 0;
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk)
        quiet |-> (o_win == '0 && !o_win_valid && !o_partial && !o_frame))
        else report_other("outputs not cleared around reset");

    a_frame: assert property (@(posedge i_clk) o_frame == frm_pipe[2])
        else report_value("o_frame", $sampled(o_frame), $sampled(frm_pipe[2]));

    a_valid: assert property (@(posedge i_clk) o_win_valid == valid_pipe[3])
        else report_value("o_win_valid", $sampled(o_win_valid), $sampled(valid_pipe[3]));

    a_partial: assert property (@(posedge i_clk) o_partial == part_pipe[3])
        else report_value("o_partial", $sampled(o_partial), $sampled(part_pipe[3]));

    a_word: assert property (@(posedge i_clk) valid_pipe[3] |-> o_win == word_pipe[3])
        else report_value("o_win", $sampled(o_win), $sampled(word_pipe[3]));

    initial begin
        seed        = 32'hf3f4da74;
        cyc         = 0;
        word_cnt    = 0;
        run_len     = 0;
        err_value   = 0;
        err_other   = 0;
        i_rst_n     = 1'b1;
        i_stream    = '0;
        ref_valid   = 1'b0;
        ref_partial = 1'b0;
        ref_word    = '0;
        frm_pipe    = '0;
        valid_pipe  = '0;
        part_pipe   = '0;
        for (int k = 0; k < 4; k++) begin
            word_pipe[k] = '0;
        end
        #1 i_rst_n = 1'b0;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        // second frame shows the row and slot counters restart
        for (int f = 0; f < 2; f++) begin
            send_frame();
            wait_words(FRAME_WORDS * (f + 1));
        end
        repeat (4) @(posedge i_clk);
        $display("errors: %0d wrong values, %0d other, %0d words seen",
                 err_value, err_other, word_cnt);
        if (err_value == 0 && err_other == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/line_window_pkg.sv
verilog/sync_tracker.sv
verilog/line_write_ctrl.sv
verilog/line_ram.sv
verilog/row_assembler.sv
verilog/line_window_top.sv
bench/tb_line_window.sv
